// File: join_top.f
+incdir+hw
hw/stream_pkg.sv
hw/csr_pkg.sv
hw/frame_join.sv
hw/axis_skid_buffer.sv
hw/join_csr.sv
hw/join_top.sv
tests/join_top_sva.sv
tests/join_top_tb.sv

// File: run.sh
#!/bin/sh
# builds the joiner testbench with Verilator and runs it; the exit status gives the result
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module join_top_tb -f join_top.f -o join_top_sim \
    && ./obj_dir/join_top_sim \
    || exit 1

// File: tests/join_top_tb.sv
// testbench for join_top that applies a table of frames and checks every output beat and register
`include "join_params.svh"

module join_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS = 6;
    localparam int TIMEOUT  = 1000;

    // len and user list port 3 first
    typedef struct packed {
        logic [3:0][2:0] len;
        logic [3:0]      user;
        logic            tag_en;
        logic [15:0]     tag;
        logic            bp;
    } row_t;

    logic                    clk, rst;
    logic [`JOIN_DATA_W-1:0] s_tdata [4];
    logic [3:0]              s_tvalid, s_tready, s_tlast, s_tuser;
    logic [`JOIN_DATA_W-1:0] m_tdata;
    logic                    m_tvalid, m_tready, m_tlast, m_tuser;
    logic [`CSR_ADDR_W-1:0]  awaddr, araddr;
    logic [`CSR_DATA_W-1:0]  wdata, rdata;
    logic                    awvalid, awready, wvalid, wready, bvalid, bready;
    logic                    arvalid, arready, rvalid, rready;
    csr_pkg::axi_resp_t      bresp, rresp;
    row_t                    rows [NUM_ROWS];
    logic [31:0]             rng;

    join_top join_top_i (
        .s0_tdata(s_tdata[0]), .s0_tvalid(s_tvalid[0]), .s0_tready(s_tready[0]),
        .s0_tlast(s_tlast[0]), .s0_tuser(s_tuser[0]),
        .s1_tdata(s_tdata[1]), .s1_tvalid(s_tvalid[1]), .s1_tready(s_tready[1]),
        .s1_tlast(s_tlast[1]), .s1_tuser(s_tuser[1]),
        .s2_tdata(s_tdata[2]), .s2_tvalid(s_tvalid[2]), .s2_tready(s_tready[2]),
        .s2_tlast(s_tlast[2]), .s2_tuser(s_tuser[2]),
        .s3_tdata(s_tdata[3]), .s3_tvalid(s_tvalid[3]), .s3_tready(s_tready[3]),
        .s3_tlast(s_tlast[3]), .s3_tuser(s_tuser[3]),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Result: FAILED");
        $fatal(1, "wait expired");
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready)) begin
            n++;
            if (n > TIMEOUT) fail_timeout("the write to be accepted");
            @(negedge clk);
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            n++;
            if (n > TIMEOUT) fail_timeout("the write response");
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n > TIMEOUT) fail_timeout("the read to be accepted");
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            n++;
            if (n > TIMEOUT) fail_timeout("the read data");
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // drives all four inputs at once and checks the joined frame beat by beat
    task automatic run_row(input row_t row);
        logic [`JOIN_DATA_W-1:0] bytes [4][8];
        logic [`JOIN_DATA_W-1:0] exp_q [$];
        int                      idx [4];
        int                      p, b, got, n, len;
        logic                    exp_user, last;
        if (row.tag_en) begin
            exp_q.push_back(row.tag[15:8]);
            exp_q.push_back(row.tag[7:0]);
        end
        for (p = 0; p < 4; p++) begin
            idx[p] = 0;
            for (b = 0; b < 8; b++) begin
                rng = xorshift32(rng);
                bytes[p][b] = rng[7:0];
                if (b < int'(row.len[p])) exp_q.push_back(bytes[p][b]);
            end
        end
        exp_user = |row.user;
        got = 0;
        n = 0;
        while (got < exp_q.size()) begin
            @(posedge clk);
            for (p = 0; p < 4; p++) begin
                len = int'(row.len[p]);
                s_tvalid[p] <= idx[p] < len;
                s_tdata[p]  <= bytes[p][idx[p]];
                s_tlast[p]  <= idx[p] == len - 1;
                s_tuser[p]  <= (idx[p] == len - 1) && row.user[p];
            end
            rng = xorshift32(rng);
            m_tready <= row.bp ? rng[3] : 1'b1;
            @(negedge clk);
            for (p = 0; p < 4; p++) begin
                if (s_tvalid[p] && s_tready[p]) idx[p]++;
            end
            if (m_tvalid && m_tready) begin
                last = got == exp_q.size() - 1;
                check_value("m_tdata", 32'(m_tdata), 32'(exp_q[got]));
                check_value("m_tlast", 32'(m_tlast), 32'(last));
                check_value("m_tuser", 32'(m_tuser), 32'(last && exp_user));
                got++;
            end
            n++;
            if (n > TIMEOUT) fail_timeout("the joined output frame");
        end
        // nothing may follow the final beat
        @(negedge clk);
        check_value("m_tvalid", 32'(m_tvalid), 32'h0);
    endtask

    initial begin
        int          r, frames_exp, errs_exp;
        logic [31:0] data;
        logic [1:0]  resp;
        rst      = 1'b1;
        rng      = 32'h339e;
        s_tvalid = '0;
        s_tlast  = '0;
        s_tuser  = '0;
        for (r = 0; r < 4; r++) s_tdata[r] = '0;
        m_tready = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        frames_exp = 0;
        errs_exp   = 0;
        rows[0] = '{len: {3'd4, 3'd3, 3'd2, 3'd1}, user: 4'b0000, tag_en: 1'b1,
                    tag: 16'hA55A, bp: 1'b0};
        rows[1] = '{len: {3'd5, 3'd2, 3'd1, 3'd3}, user: 4'b0100, tag_en: 1'b0,
                    tag: 16'h0F0F, bp: 1'b0};
        rows[2] = '{len: {3'd1, 3'd1, 3'd1, 3'd1}, user: 4'b0000, tag_en: 1'b0,
                    tag: 16'h0000, bp: 1'b0};
        rows[3] = '{len: {3'd5, 3'd5, 3'd5, 3'd5}, user: 4'b1001, tag_en: 1'b1,
                    tag: 16'h1234, bp: 1'b1};
        rows[4] = '{len: {3'd3, 3'd1, 3'd4, 3'd2}, user: 4'b0010, tag_en: 1'b1,
                    tag: 16'hBEEF, bp: 1'b1};
        rows[5] = '{len: {3'd1, 3'd5, 3'd2, 3'd4}, user: 4'b0000, tag_en: 1'b0,
                    tag: 16'hC001, bp: 1'b1};
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (r = 0; r < NUM_ROWS; r++) begin
            axi_write(csr_pkg::reg_ctrl, {31'b0, rows[r].tag_en}, resp);
            check_value("bresp", 32'(resp), 32'(csr_pkg::resp_okay));
            axi_write(csr_pkg::reg_tag, {16'b0, rows[r].tag}, resp);
            check_value("bresp", 32'(resp), 32'(csr_pkg::resp_okay));
            run_row(rows[r]);
            frames_exp++;
            if (|rows[r].user) errs_exp++;
        end

        // counters, status and control after the last frame
        axi_read(csr_pkg::reg_frames, data, resp);
        check_value("rresp", 32'(resp), 32'(csr_pkg::resp_okay));
        check_value("reg_frames", data, {errs_exp[15:0], frames_exp[15:0]});
        axi_read(csr_pkg::reg_status, data, resp);
        check_value("reg_status", data, 32'h0);
        axi_read(csr_pkg::reg_ctrl, data, resp);
        check_value("reg_ctrl", data, {31'b0, rows[NUM_ROWS-1].tag_en});

        // status is read only
        axi_write(csr_pkg::reg_status, 32'h1, resp);
        check_value("bresp", 32'(resp), 32'(csr_pkg::resp_slverr));
        axi_read(csr_pkg::reg_status, data, resp);
        check_value("rresp", 32'(resp), 32'(csr_pkg::resp_okay));
        check_value("reg_status", data, 32'h0);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: tests/join_top_sva.sv
// protocol assertions for the frame joiner that are bound into join_top beside the testbench
`include "join_params.svh"

module join_top_sva (
    input logic                    clk,
    input logic                    rst,
    input logic                    s0_tready,
    input logic                    s1_tready,
    input logic                    s2_tready,
    input logic                    s3_tready,
    input logic [`JOIN_DATA_W-1:0] m_tdata,
    input logic                    m_tvalid,
    input logic                    m_tready,
    input logic                    m_tlast,
    input logic                    bvalid,
    input logic                    bready,
    input logic                    rvalid,
    input logic                    rready,
    input logic                    busy
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled output beat holds until it is taken
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
        else $error("m_ beat changed while stalled");

    one_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0({s3_tready, s2_tready, s1_tready, s0_tready}))
        else $error("more than one input ready");

    bresp_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rresp_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // inputs stay closed whenever the joiner is idle
    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !busy |-> !s0_tready && !s1_tready && !s2_tready && !s3_tready)
        else $error("input ready while the joiner is idle");

endmodule

bind join_top join_top_sva join_top_sva_i (.*);

// File: hw/join_top.sv
// top level that wires the joiner FSM to the output skid buffer and the AXI4-Lite registers
`include "join_params.svh"

module join_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`JOIN_DATA_W-1:0] s0_tdata,
    input  logic                    s0_tvalid,
    output logic                    s0_tready,
    input  logic                    s0_tlast,
    input  logic                    s0_tuser,
    input  logic [`JOIN_DATA_W-1:0] s1_tdata,
    input  logic                    s1_tvalid,
    output logic                    s1_tready,
    input  logic                    s1_tlast,
    input  logic                    s1_tuser,
    input  logic [`JOIN_DATA_W-1:0] s2_tdata,
    input  logic                    s2_tvalid,
    output logic                    s2_tready,
    input  logic                    s2_tlast,
    input  logic                    s2_tuser,
    input  logic [`JOIN_DATA_W-1:0] s3_tdata,
    input  logic                    s3_tvalid,
    output logic                    s3_tready,
    input  logic                    s3_tlast,
    input  logic                    s3_tuser,
    output logic [`JOIN_DATA_W-1:0] m_tdata,
    output logic                    m_tvalid,
    input  logic                    m_tready,
    output logic                    m_tlast,
    output logic                    m_tuser,
    input  logic [`CSR_ADDR_W-1:0]  awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`CSR_DATA_W-1:0]  wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output csr_pkg::axi_resp_t      bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`CSR_ADDR_W-1:0]  araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`CSR_DATA_W-1:0]  rdata,
    output csr_pkg::axi_resp_t      rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    logic [`JOIN_DATA_W-1:0] mid_tdata;
    logic                    mid_tvalid, mid_tlast, mid_tuser, mid_tready_early;
    logic [`JOIN_TAG_W-1:0]  tag;
    logic                    tag_enable, busy;

    frame_join frame_join_i (.*);

    axis_skid_buffer skid_i (.*);

    // counters watch the beats leaving on the m_ port
    join_csr csr_i (.*);

endmodule

// File: hw/join_csr.sv
// AXI4-Lite register block for tag control, busy status and output frame counters
`include "join_params.svh"

module join_csr (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`CSR_ADDR_W-1:0]  awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`CSR_DATA_W-1:0]  wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output csr_pkg::axi_resp_t      bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`CSR_ADDR_W-1:0]  araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`CSR_DATA_W-1:0]  rdata,
    output csr_pkg::axi_resp_t      rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  logic                    busy,
    input  logic                    m_tvalid,
    input  logic                    m_tready,
    input  logic                    m_tlast,
    input  logic                    m_tuser,
    output logic [`JOIN_TAG_W-1:0]  tag,
    output logic                    tag_enable
);

    csr_pkg::reg_addr_t wr_addr, rd_addr;
    logic               wr_accept, rd_accept, wr_ok;
    logic               frame_done;
    logic [15:0]        frame_cnt, err_cnt;

    assign wr_addr = csr_pkg::reg_addr_t'(awaddr);
    assign rd_addr = csr_pkg::reg_addr_t'(araddr);

    // one transaction in flight per direction
    assign wr_accept = awvalid & wvalid & ~bvalid;
    assign rd_accept = arvalid & ~rvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;

    assign wr_ok      = (wr_addr == csr_pkg::reg_ctrl) || (wr_addr == csr_pkg::reg_tag);
    assign frame_done = m_tvalid & m_tready & m_tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            tag_enable <= 1'b1;
            tag        <= '0;
            frame_cnt  <= '0;
            err_cnt    <= '0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_accept && wr_addr == csr_pkg::reg_ctrl) begin
                tag_enable <= wdata[0];
            end
            if (wr_accept && wr_addr == csr_pkg::reg_tag) begin
                tag <= wdata[`JOIN_TAG_W-1:0];
            end
            // both counters wrap at 16 bits
            if (frame_done) begin
                frame_cnt <= frame_cnt + 16'd1;
                if (m_tuser) begin
                    err_cnt <= err_cnt + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_ok ? csr_pkg::resp_okay : csr_pkg::resp_slverr;
        end
        if (rd_accept) begin
            rdata <= '0;
            rresp <= csr_pkg::resp_okay;
            case (rd_addr)
                csr_pkg::reg_ctrl:   rdata[0] <= tag_enable;
                csr_pkg::reg_tag:    rdata[`JOIN_TAG_W-1:0] <= tag;
                csr_pkg::reg_status: rdata[0] <= busy;
                csr_pkg::reg_frames: rdata <= {err_cnt, frame_cnt};
                default:             rresp <= csr_pkg::resp_slverr;
            endcase
        end
    end

endmodule

// File: hw/axis_skid_buffer.sv
// registered output stage between the joiner and the m_ port that keeps one beat per cycle
`include "join_params.svh"

module axis_skid_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`JOIN_DATA_W-1:0] mid_tdata,
    input  logic                    mid_tvalid,
    input  logic                    mid_tlast,
    input  logic                    mid_tuser,
    output logic                    mid_tready_early,
    output logic [`JOIN_DATA_W-1:0] m_tdata,
    output logic                    m_tvalid,
    input  logic                    m_tready,
    output logic                    m_tlast,
    output logic                    m_tuser
);

    logic [`JOIN_DATA_W-1:0] temp_tdata;
    logic                    temp_tvalid, temp_tlast, temp_tuser;
    logic                    out_valid_next, temp_valid_next;
    logic                    load_out, load_temp, temp_to_out;

    // ready next cycle unless a beat would have to wait behind a full temp register
    assign mid_tready_early = m_tready | (~temp_tvalid & (~m_tvalid | ~mid_tvalid));

    always_comb begin
        out_valid_next  = m_tvalid;
        temp_valid_next = temp_tvalid;
        load_out        = 1'b0;
        load_temp       = 1'b0;
        temp_to_out     = 1'b0;
        // mid_tvalid only rises while the registered ready is high
        if (mid_tvalid) begin
            if (m_tready || !m_tvalid) begin
                out_valid_next = 1'b1;
                load_out       = 1'b1;
            end else begin
                temp_valid_next = 1'b1;
                load_temp       = 1'b1;
            end
        end else if (m_tready) begin
            out_valid_next  = temp_tvalid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid    <= 1'b0;
            temp_tvalid <= 1'b0;
        end else begin
            m_tvalid    <= out_valid_next;
            temp_tvalid <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            {m_tdata, m_tlast, m_tuser} <= {mid_tdata, mid_tlast, mid_tuser};
        end else if (temp_to_out) begin
            {m_tdata, m_tlast, m_tuser} <= {temp_tdata, temp_tlast, temp_tuser};
        end
        if (load_temp) begin
            {temp_tdata, temp_tlast, temp_tuser} <= {mid_tdata, mid_tlast, mid_tuser};
        end
    end

endmodule

// File: hw/frame_join.sv
// joiner FSM that sends an optional tag and then one frame from each input in port order
`include "join_params.svh"

module frame_join (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`JOIN_DATA_W-1:0]  s0_tdata,
    input  logic                     s0_tvalid,
    output logic                     s0_tready,
    input  logic                     s0_tlast,
    input  logic                     s0_tuser,
    input  logic [`JOIN_DATA_W-1:0]  s1_tdata,
    input  logic                     s1_tvalid,
    output logic                     s1_tready,
    input  logic                     s1_tlast,
    input  logic                     s1_tuser,
    input  logic [`JOIN_DATA_W-1:0]  s2_tdata,
    input  logic                     s2_tvalid,
    output logic                     s2_tready,
    input  logic                     s2_tlast,
    input  logic                     s2_tuser,
    input  logic [`JOIN_DATA_W-1:0]  s3_tdata,
    input  logic                     s3_tvalid,
    output logic                     s3_tready,
    input  logic                     s3_tlast,
    input  logic                     s3_tuser,
    output logic [`JOIN_DATA_W-1:0]  mid_tdata,
    output logic                     mid_tvalid,
    output logic                     mid_tlast,
    output logic                     mid_tuser,
    input  logic                     mid_tready_early,
    input  logic [`JOIN_TAG_W-1:0]   tag,
    input  logic                     tag_enable,
    output logic                     busy
);

    stream_pkg::join_state_t state, state_next;
    stream_pkg::port_sel_t   port_sel, port_next;
    logic [1:0]              tag_idx, tag_idx_next;
    logic [`JOIN_PORTS-1:0]  ready_q, ready_next;
    logic                    mid_ready_q;
    logic                    user_acc, user_next;
    logic [`JOIN_TAG_W-1:0]  tag_q;
    logic                    tag_en_q;
    logic                    xfer;
    logic [`JOIN_DATA_W-1:0] in_tdata;
    logic                    in_tvalid, in_tlast, in_tuser;
    logic [`JOIN_DATA_W-1:0] tag_byte;

    assign s0_tready = ready_q[0];
    assign s1_tready = ready_q[1];
    assign s2_tready = ready_q[2];
    assign s3_tready = ready_q[3];

    // tag bytes go out most significant first
    assign tag_byte = tag_q[(`JOIN_TAG_BYTES - 1 - tag_idx) * `JOIN_DATA_W +: `JOIN_DATA_W];

    always_comb begin
        case (port_sel)
            2'd0: {in_tdata, in_tvalid, in_tlast, in_tuser} =
                {s0_tdata, s0_tvalid, s0_tlast, s0_tuser};
            2'd1: {in_tdata, in_tvalid, in_tlast, in_tuser} =
                {s1_tdata, s1_tvalid, s1_tlast, s1_tuser};
            2'd2: {in_tdata, in_tvalid, in_tlast, in_tuser} =
                {s2_tdata, s2_tvalid, s2_tlast, s2_tuser};
            default: {in_tdata, in_tvalid, in_tlast, in_tuser} =
                {s3_tdata, s3_tvalid, s3_tlast, s3_tuser};
        endcase
    end

    always_comb begin
        state_next   = state;
        port_next    = port_sel;
        tag_idx_next = tag_idx;
        user_next    = user_acc;
        ready_next   = '0;
        mid_tdata    = '0;
        mid_tvalid   = 1'b0;
        mid_tlast    = 1'b0;
        mid_tuser    = 1'b0;
        xfer         = 1'b0;
        case (state)
            stream_pkg::st_idle: begin
                if (s0_tvalid) begin
                    if (tag_en_q) begin
                        // first tag byte may leave in the cycle the frame starts
                        state_next = stream_pkg::st_tag;
                        if (mid_ready_q) begin
                            mid_tdata    = tag_byte;
                            mid_tvalid   = 1'b1;
                            tag_idx_next = tag_idx + 2'd1;
                        end
                    end else begin
                        state_next = stream_pkg::st_xfer;
                        xfer       = 1'b1;
                    end
                end
            end
            stream_pkg::st_tag: begin
                if (mid_ready_q) begin
                    mid_tdata  = tag_byte;
                    mid_tvalid = 1'b1;
                    if (tag_idx == 2'(`JOIN_TAG_BYTES - 1)) begin
                        tag_idx_next  = '0;
                        state_next    = stream_pkg::st_xfer;
                        ready_next[0] = mid_tready_early;
                    end else begin
                        tag_idx_next = tag_idx + 2'd1;
                    end
                end
            end
            default: xfer = 1'b1;
        endcase

        if (xfer) begin
            ready_next[port_sel] = mid_tready_early;
            if (in_tvalid && ready_q[port_sel]) begin
                mid_tdata  = in_tdata;
                mid_tvalid = 1'b1;
                if (in_tlast) begin
                    port_next  = stream_pkg::port_sel_t'(port_sel + 2'd1);
                    ready_next = '0;
                    if (port_sel == 2'd3) begin
                        // final beat carries tlast and any error seen on the four frames
                        mid_tlast  = 1'b1;
                        mid_tuser  = user_acc | in_tuser;
                        user_next  = 1'b0;
                        state_next = stream_pkg::st_idle;
                    end else begin
                        user_next             = user_acc | in_tuser;
                        ready_next[port_next] = mid_tready_early;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= stream_pkg::st_idle;
            port_sel    <= '0;
            tag_idx     <= '0;
            ready_q     <= '0;
            mid_ready_q <= 1'b0;
            user_acc    <= 1'b0;
            busy        <= 1'b0;
            tag_en_q    <= 1'b0;
        end else begin
            state       <= state_next;
            port_sel    <= port_next;
            tag_idx     <= tag_idx_next;
            ready_q     <= ready_next;
            mid_ready_q <= mid_tready_early;
            user_acc    <= user_next;
            busy        <= state_next != stream_pkg::st_idle;
            // tag settings freeze once a frame has started
            if (state_next == stream_pkg::st_idle) begin
                tag_en_q <= tag_enable;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_next == stream_pkg::st_idle) begin
            tag_q <= tag;
        end
    end

endmodule

// File: hw/csr_pkg.sv
// register-side types of the joiner control block, referenced by scoped name
package csr_pkg;

    // byte offsets of the AXI4-Lite registers
    typedef enum logic [3:0] {
        reg_ctrl   = 4'h0,
        reg_tag    = 4'h4,
        reg_status = 4'h8,
        reg_frames = 4'hC
    } reg_addr_t;

    // AXI4-Lite response codes that the slave can return
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

endpackage

// File: hw/stream_pkg.sv
// stream-side types of the frame joiner, referenced by scoped name from the joiner RTL
package stream_pkg;

    // joiner FSM states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_tag  = 2'd1,
        st_xfer = 2'd2
    } join_state_t;

    // index of the input currently routed to the output
    typedef logic [1:0] port_sel_t;

endpackage

// File: hw/join_params.svh
// sizes shared by the joiner RTL; include in every file that sizes a port or a register
`ifndef JOIN_PARAMS_SVH
`define JOIN_PARAMS_SVH

// stream side
`define JOIN_PORTS 4
`define JOIN_DATA_W 8
`define JOIN_TAG_BYTES 2
`define JOIN_TAG_W 16

// register side
`define CSR_ADDR_W 4
`define CSR_DATA_W 32

`endif
